// File: div_config.svh
`ifndef DIV_CONFIG_SVH
`define DIV_CONFIG_SVH

// operand width in bits, one restoring step per bit
`define DIV_WIDTH 8

// width of the caller's request tag
`define DIV_TAG_WIDTH 4

// entry stage + one stage per quotient bit + result stage
`define DIV_LATENCY (`DIV_WIDTH + 2)

`endif

// File: div_pkg.sv
`include "div_config.svh"

package div_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // scalar widths
    // ~~~~~~~~~~~~~~~~~~~~

    typedef logic [`DIV_WIDTH-1:0] operand_t;

    // one bit wider so the shifted remainder cannot overflow
    typedef logic [`DIV_WIDTH:0] prem_t;

    typedef logic [`DIV_TAG_WIDTH-1:0] tag_t;

    // ~~~~~~~~~~~~~~~~~~~~
    // bundles
    // ~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        tag_t     tag;
        operand_t dividend;
        operand_t divisor;
    } div_req_t;

    // shreg starts as the dividend; each step shifts one dividend bit out at
    // the top and one quotient bit in at the bottom
    typedef struct packed {
        tag_t     tag;
        operand_t shreg;
        prem_t    prem;
        operand_t divisor;
        logic     dbz;
    } div_work_t;

    typedef struct packed {
        tag_t     tag;
        operand_t quotient;
        operand_t remainder;
        logic     dbz;
    } div_res_t;

endpackage

// File: div_entry_stage.sv
`timescale 1ns/1ps

module div_entry_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    input  div_pkg::div_req_t   req,
    output logic                work_valid,
    output div_pkg::div_work_t  work
);

    div_pkg::div_work_t init_work;

    // the initial work word: the whole dividend still to be consumed and an
    // empty partial remainder
    always_comb begin
        init_work.tag     = req.tag;
        init_work.shreg   = req.dividend;
        init_work.prem    = '0;
        init_work.divisor = req.divisor;
        init_work.dbz     = (req.divisor == '0);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            work_valid <= 1'b0;
            work       <= '0;
        end else begin
            work_valid <= in_valid;
            // hold the last word across bubbles
            if (in_valid) begin
                work <= init_work;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // input checks
    // ~~~~~~~~~~~~~~~~~~~~

    // an unknown strobe would smear X through every stage of the pipe
    a_in_valid_known : assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(in_valid)
    );

    a_req_known : assert property (
        @(posedge clk) disable iff (!rst_n)
        in_valid |-> !$isunknown(req)
    );

endmodule

// File: div_step_stage.sv
`timescale 1ns/1ps

`include "div_config.svh"

module div_step_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    input  div_pkg::div_work_t  in_work,
    output logic                out_valid,
    output div_pkg::div_work_t  out_work
);

    localparam int W = `DIV_WIDTH;

    div_pkg::prem_t     shifted;
    div_pkg::prem_t     diff;
    div_pkg::prem_t     divisor_ext;
    logic               fits;
    div_pkg::div_work_t nxt_work;

    // ~~~~~~~~~~~~~~~~~~~~
    // one restoring step
    // ~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        // bring down the next dividend bit from the top of the shift register
        shifted     = {in_work.prem[W-1:0], in_work.shreg[W-1]};
        divisor_ext = {1'b0, in_work.divisor};
        diff        = shifted - divisor_ext;
        fits        = (shifted >= divisor_ext);

        nxt_work = in_work;
        // restore by simply keeping the unsubtracted value
        nxt_work.prem  = fits ? diff : shifted;
        nxt_work.shreg = {in_work.shreg[W-2:0], fits};
    end

    // a zero divisor always fits, so the quotient fills with ones and
    // prem ends up holding the dividend without any special case here

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_work  <= '0;
        end else begin
            out_valid <= in_valid;
            if (in_valid) begin
                out_work <= nxt_work;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~

    // restoring invariant, which only holds if every earlier stage kept it too
    a_prem_below_divisor : assert property (
        @(posedge clk) disable iff (!rst_n)
        (out_valid && !out_work.dbz) |-> (out_work.prem < {1'b0, out_work.divisor})
    );

endmodule

// File: div_result_stage.sv
`timescale 1ns/1ps

`include "div_config.svh"

module div_result_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    input  div_pkg::div_work_t  in_work,
    output logic                out_valid,
    output div_pkg::div_res_t   res
);

    localparam int W = `DIV_WIDTH;

    div_pkg::div_res_t nxt_res;

    always_comb begin
        nxt_res.tag = in_work.tag;
        nxt_res.dbz = in_work.dbz;
        // after the last step every shreg bit is a quotient bit
        nxt_res.quotient = in_work.shreg;
        // the top bit of prem is always zero here
        nxt_res.remainder = in_work.prem[W-1:0];

        // divide by zero gives all ones; prem already carries the dividend
        // since every step subtracted zero
        if (in_work.dbz) begin
            nxt_res.quotient = '1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            res       <= '0;
        end else begin
            out_valid <= in_valid;
            if (in_valid) begin
                res <= nxt_res;
            end
        end
    end

    // the divisor is dropped from the result, so compare against the one
    // that came in with this word a cycle earlier
    a_rem_below_divisor : assert property (
        @(posedge clk) disable iff (!rst_n)
        (out_valid && !res.dbz) |-> (res.remainder < $past(in_work.divisor))
    );

endmodule

// File: div_pipe_top.sv
`timescale 1ns/1ps

`include "div_config.svh"

module div_pipe_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    input  div_pkg::div_req_t  req,
    output logic               out_valid,
    output div_pkg::div_res_t  res
);

    // ~~~~~~~~~~~~~~~~~~~~
    // stage links
    // ~~~~~~~~~~~~~~~~~~~~

    // index 0 comes from the entry stage, index DIV_WIDTH feeds the result stage
    logic [`DIV_WIDTH:0] stage_valid;
    div_pkg::div_work_t  stage_work [0:`DIV_WIDTH];

    div_entry_stage u_entry (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .req        (req),
        .work_valid (stage_valid[0]),
        .work       (stage_work[0])
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // one stage per quotient bit, msb first
    // ~~~~~~~~~~~~~~~~~~~~

    for (genvar k = 0; k < `DIV_WIDTH; k++) begin : g_step
        div_step_stage u_step (
            .clk       (clk),
            .rst_n     (rst_n),
            .in_valid  (stage_valid[k]),
            .in_work   (stage_work[k]),
            .out_valid (stage_valid[k+1]),
            .out_work  (stage_work[k+1])
        );
    end

    div_result_stage u_result (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (stage_valid[`DIV_WIDTH]),
        .in_work   (stage_work[`DIV_WIDTH]),
        .out_valid (out_valid),
        .res       (res)
    );

endmodule

// File: tb_div_pipe.sv
`timescale 1ns/1ps

`include "div_config.svh"

module tb_div_pipe;

    localparam int W          = `DIV_WIDTH;
    localparam int L          = `DIV_LATENCY;
    localparam int N_BURST    = 500;
    localparam int N_RANDOM   = 2000;
    localparam int N_OPS      = N_BURST + N_RANDOM + 64;
    localparam int WATCHDOG_CYCLES = N_OPS * L + 500;

    logic               clk = 1'b0;
    logic               rst_n;
    logic               in_valid;
    div_pkg::div_req_t  req;
    logic               out_valid;
    div_pkg::div_res_t  res;

    logic [31:0]        lfsr;
    div_pkg::tag_t      next_tag;
    string              test_name;
    // name of the phase that drove the request now on req
    string              req_name;

    // reference history, entry L-1 is the request whose result is due now
    logic [L-1:0]       hist_valid;
    div_pkg::div_req_t  hist_req [0:L-1];
    string              hist_name [0:L-1];
    div_pkg::div_res_t  exp_res;

    always #5 clk = ~clk;

    div_pipe_top u_div_pipe_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .req       (req),
        .out_valid (out_valid),
        .res       (res)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~

    function automatic div_pkg::div_res_t expected_result(input div_pkg::div_req_t r);
        div_pkg::div_res_t e;
        e.tag = r.tag;
        if (r.divisor == '0) begin
            // common processor convention for a zero divisor
            e.dbz       = 1'b1;
            e.quotient  = '1;
            e.remainder = r.dividend;
        end else begin
            e.dbz       = 1'b0;
            e.quotient  = r.dividend / r.divisor;
            e.remainder = r.dividend % r.divisor;
        end
        return e;
    endfunction

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hist_valid <= '0;
            for (int i = 0; i < L; i++) begin
                hist_req[i]  <= '0;
                hist_name[i] <= "reset";
            end
        end else begin
            hist_valid   <= {hist_valid[L-2:0], in_valid};
            hist_req[0]  <= in_valid ? req : '0;
            hist_name[0] <= req_name;
            for (int i = 1; i < L; i++) begin
                hist_req[i]  <= hist_req[i-1];
                hist_name[i] <= hist_name[i-1];
            end
        end
    end

    always_comb exp_res = expected_result(hist_req[L-1]);

    // ~~~~~~~~~~~~~~~~~~~~
    // failure reporting
    // ~~~~~~~~~~~~~~~~~~~~

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input string what,
                                   input logic [31:0] exp_v, input logic [31:0] act_v);
        fail_run($sformatf("mismatch in %s: %s expected %0h actual %0h",
                           name, what, exp_v, act_v));
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~

    // checked mid-cycle, where every registered output has settled
    a_quiet_in_reset : assert property (@(negedge clk) !rst_n |-> !out_valid)
        else fail_run("out_valid was high while reset was asserted");

    a_valid_timing : assert property (
        @(negedge clk) disable iff (!rst_n) out_valid == hist_valid[L-1]
    ) else report_mismatch(hist_name[L-1], "out_valid",
                           32'(hist_valid[L-1]), 32'(out_valid));

    a_tag_order : assert property (
        @(negedge clk) disable iff (!rst_n) out_valid |-> res.tag == exp_res.tag
    ) else report_mismatch(hist_name[L-1], "tag", 32'(exp_res.tag), 32'(res.tag));

    a_dbz : assert property (
        @(negedge clk) disable iff (!rst_n) out_valid |-> res.dbz == exp_res.dbz
    ) else report_mismatch(hist_name[L-1], "dbz", 32'(exp_res.dbz), 32'(res.dbz));

    a_quotient : assert property (
        @(negedge clk) disable iff (!rst_n) out_valid |-> res.quotient == exp_res.quotient
    ) else report_mismatch(hist_name[L-1], "quotient",
                           32'(exp_res.quotient), 32'(res.quotient));

    a_remainder : assert property (
        @(negedge clk) disable iff (!rst_n) out_valid |-> res.remainder == exp_res.remainder
    ) else report_mismatch(hist_name[L-1], "remainder",
                           32'(exp_res.remainder), 32'(res.remainder));

    // ~~~~~~~~~~~~~~~~~~~~
    // stimulus helpers
    // ~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic rand_operand(output div_pkg::operand_t v);
        logic [31:0] bits;
        take_bits(W, bits);
        v = bits[W-1:0];
    endtask

    task automatic send(input div_pkg::operand_t dividend, input div_pkg::operand_t divisor);
        div_pkg::div_req_t r;
        r.tag      = next_tag;
        r.dividend = dividend;
        r.divisor  = divisor;
        @(posedge clk);
        in_valid <= 1'b1;
        req      <= r;
        req_name <= test_name;
        next_tag = next_tag + 1'b1;
    endtask

    task automatic idle();
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    // random request, with a narrowed divisor half the time for larger quotients
    task automatic send_random();
        div_pkg::operand_t a;
        div_pkg::operand_t b;
        logic [31:0]       bits;
        rand_operand(a);
        rand_operand(b);
        take_bits(1, bits);
        if (bits[0]) begin
            b = b >> (W / 2);
        end
        send(a, b);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // test sequence
    // ~~~~~~~~~~~~~~~~~~~~

    initial begin
        div_pkg::operand_t a;
        logic [31:0]       bits;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        req       = '0;
        lfsr      = 32'hf17fd827;
        next_tag  = '0;
        test_name = "reset";
        req_name  = "reset";

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        // out_valid has to stay low while the empty pipe drains
        repeat (L + 2) @(posedge clk);

        test_name = "edge_cases";
        send('0, 8'h01);
        send('0, '1);
        send('0, 8'h37);
        send(8'h5a, 8'h01);
        send('1, 8'h01);
        send(8'h5a, 8'h5a);
        send('1, '1);
        send(8'h01, 8'h01);
        send('1, 8'h10);
        send('1, 8'h03);
        send(8'h80, '1);
        send('0, '0);
        idle();

        test_name = "zero_divisor";
        send('1, '0);
        for (int i = 0; i < 8; i++) begin
            rand_operand(a);
            send(a, '0);
        end
        idle();

        // back to back, one request per cycle
        test_name = "throughput";
        for (int i = 0; i < N_BURST; i++) begin
            send_random();
        end

        test_name = "random_gaps";
        for (int i = 0; i < N_RANDOM; i++) begin
            take_bits(2, bits);
            if (bits[1:0] == 2'b00) begin
                take_bits(2, bits);
                repeat (int'(bits[1:0]) + 1) idle();
            end
            send_random();
        end
        idle();

        test_name = "drain";
        repeat (L + 2) @(posedge clk);
        $display("Simulation PASSED");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        fail_run("timeout: the test sequence did not finish in the expected time");
    end

endmodule

// File: all.f
+incdir+.
div_pkg.sv
div_entry_stage.sv
div_step_stage.sv
div_result_stage.sv
div_pipe_top.sv
tb_div_pipe.sv

// File: run.sh
#!/bin/sh
# compile and run the divider testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_div_pipe -o sim_div_pipe
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

out=$(./obj_dir/sim_div_pipe 2>&1)
status=$?
printf '%s\n' "$out"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation PASSED"; then
    exit 0
else
    echo "pass message not found"
    exit 1
fi
